// File: filelist.f
hdl/sb_pkg.sv
hdl/sb_entry_store.sv
hdl/sb_clobber_table.sv
hdl/sb_operand_fwd.sv
hdl/scoreboard.sv
sim/sb_checker.sv
sim/tb_scoreboard.sv

// File: Makefile
TOP := tb_scoreboard

.PHONY: all lint clean

# build and run, pass only when the pass line shows up
all:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^TEST OK$$" > /dev/null

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/tb_scoreboard.sv
// Scoreboard testbench
`default_nettype none
`timescale 1ns/100ps

module tb_scoreboard;

  import sb_pkg::*;

  localparam int          NrCycles    = 2000;
  localparam int          ResetCycles = 16;
  localparam int          ClkPeriod   = 100;
  localparam int          DriveDelay  = 10;
  // run length plus margin, in ns
  localparam int          WatchdogNs  = (NrCycles + 100) * ClkPeriod;
  localparam logic [31:0] LfsrSeed    = 32'h1568;
  // maximal length taps, shifting right
  localparam logic [31:0] LfsrTaps    = 32'hd000_0001;

  logic                          clk;
  logic                          rst_n;
  sb_decoded_t                   decoded;
  logic                          decoded_valid;
  logic                          decoded_ack;
  sb_entry_t                     issue;
  logic                          issue_valid;
  logic                          issue_ack;
  logic                          unresolved_branch;
  logic                          flush_unissued;
  logic                          flush;
  logic                          sb_full;
  sb_wb_t   [NrWbPorts-1:0]      wb;
  sb_entry_t                     commit;
  logic                          commit_ack;
  fu_t      [NrRegs-1:0]         clobber;
  reg_addr_t                     rs1;
  reg_addr_t                     rs2;
  xlen_t                         rs1_data;
  xlen_t                         rs2_data;
  logic                          rs1_valid;
  logic                          rs2_valid;
  logic     [SbEntries-1:0]      wb_open;
  int                            error_count;
  logic     [31:0]               lfsr;

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // random source
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // ----------------------------------------------------------
  // stimulus for one cycle
  // ----------------------------------------------------------
  task automatic drive_cycle();
    logic [31:0]          r;
    logic [SbEntries-1:0] open;
    sb_wb_t [NrWbPorts-1:0] wb_n;
    int unsigned          start;
    int unsigned          idx;
    int                   pick;
    draw(7, r);
    flush = (r[6:0] == '0);
    draw(4, r);
    flush_unissued = (r[3:0] == '0);
    draw(3, r);
    unresolved_branch = (r[2:0] == '0);
    draw(1, r);
    decoded_valid = r[0];
    draw(2, r);
    decoded.fu = fu_t'(r[1:0]);
    // narrow rd range so registers collide
    draw(3, r);
    decoded.rd = reg_addr_t'(r[2:0]);
    // full and the commit head are registered, stable here
    draw(2, r);
    issue_ack = decoded_valid & ~unresolved_branch & ~sb_full & (r[1:0] != 2'b00);
    draw(1, r);
    commit_ack = commit.valid & r[0];
    draw(3, r);
    rs1 = reg_addr_t'(r[2:0]);
    draw(3, r);
    rs2 = reg_addr_t'(r[2:0]);
    // distinct targets per cycle, taken from the open set
    open = wb_open;
    wb_n = '0;
    for (int p = 0; p < int'(NrWbPorts); p++) begin
      draw(1, r);
      if (r[0] && open != '0) begin
        draw(3, r);
        start = r[2:0];
        pick  = -1;
        for (int k = 0; k < int'(SbEntries); k++) begin
          idx = (start + k) % SbEntries;
          if (pick < 0 && open[idx]) begin
            pick = int'(idx);
          end
        end
        open[pick]        = 1'b0;
        wb_n[p].valid     = 1'b1;
        wb_n[p].trans_id  = trans_id_t'(pick);
        draw(32, r);
        wb_n[p].data      = r;
        draw(3, r);
        wb_n[p].ex_valid  = (r[2:0] == '0);
      end
    end
    wb = wb_n;
  endtask

  initial begin
    lfsr              = LfsrSeed;
    rst_n             = 1'b0;
    decoded           = '0;
    decoded_valid     = 1'b0;
    issue_ack         = 1'b0;
    unresolved_branch = 1'b0;
    flush_unissued    = 1'b0;
    flush             = 1'b0;
    wb                = '0;
    commit_ack        = 1'b0;
    rs1               = '0;
    rs2               = '0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    repeat (NrCycles) begin
      @(posedge clk);
      #DriveDelay;
      drive_cycle();
    end
    // last stimulus still needs its edge
    @(posedge clk);
    #DriveDelay;
    $display("scoreboard run: %0d cycles, %0d errors", NrCycles, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #WatchdogNs;
    $display("timeout: the run did not end within %0d cycles", NrCycles + 100);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // DUT and checker
  // ----------------------------------------------------------
  scoreboard u_scoreboard (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .decoded_i           (decoded),
    .decoded_valid_i     (decoded_valid),
    .decoded_ack_o       (decoded_ack),
    .issue_o             (issue),
    .issue_valid_o       (issue_valid),
    .issue_ack_i         (issue_ack),
    .unresolved_branch_i (unresolved_branch),
    .flush_unissued_i    (flush_unissued),
    .flush_i             (flush),
    .sb_full_o           (sb_full),
    .wb_i                (wb),
    .commit_o            (commit),
    .commit_ack_i        (commit_ack),
    .clobber_o           (clobber),
    .rs1_i               (rs1),
    .rs1_o               (rs1_data),
    .rs1_valid_o         (rs1_valid),
    .rs2_i               (rs2),
    .rs2_o               (rs2_data),
    .rs2_valid_o         (rs2_valid)
  );

  sb_checker u_checker (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .decoded_i           (decoded),
    .decoded_valid_i     (decoded_valid),
    .unresolved_branch_i (unresolved_branch),
    .flush_unissued_i    (flush_unissued),
    .flush_i             (flush),
    .issue_ack_i         (issue_ack),
    .wb_i                (wb),
    .commit_ack_i        (commit_ack),
    .rs1_i               (rs1),
    .rs2_i               (rs2),
    .decoded_ack_i       (decoded_ack),
    .issue_i             (issue),
    .issue_valid_i       (issue_valid),
    .sb_full_i           (sb_full),
    .commit_i            (commit),
    .clobber_i           (clobber),
    .rs1_data_i          (rs1_data),
    .rs1_valid_i         (rs1_valid),
    .rs2_data_i          (rs2_data),
    .rs2_valid_i         (rs2_valid),
    .wb_open_o           (wb_open),
    .error_count_o       (error_count)
  );

endmodule

`default_nettype wire

// File: sim/sb_checker.sv
// Scoreboard reference checker
`default_nettype none
`timescale 1ns/100ps

module sb_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // stimulus as seen by the DUT
  input  sb_pkg::sb_decoded_t                     decoded_i,
  input  logic                                    decoded_valid_i,
  input  logic                                    unresolved_branch_i,
  input  logic                                    flush_unissued_i,
  input  logic                                    flush_i,
  input  logic                                    issue_ack_i,
  input  sb_pkg::sb_wb_t [sb_pkg::NrWbPorts-1:0]  wb_i,
  input  logic                                    commit_ack_i,
  input  sb_pkg::reg_addr_t                       rs1_i,
  input  sb_pkg::reg_addr_t                       rs2_i,
  // DUT responses
  input  logic                                    decoded_ack_i,
  input  sb_pkg::sb_entry_t                       issue_i,
  input  logic                                    issue_valid_i,
  input  logic                                    sb_full_i,
  input  sb_pkg::sb_entry_t                       commit_i,
  input  sb_pkg::fu_t    [sb_pkg::NrRegs-1:0]     clobber_i,
  input  sb_pkg::xlen_t                           rs1_data_i,
  input  logic                                    rs1_valid_i,
  input  sb_pkg::xlen_t                           rs2_data_i,
  input  logic                                    rs2_valid_i,
  // entries that may still take a write-back
  output logic           [sb_pkg::SbEntries-1:0]  wb_open_o,
  output int                                      error_count_o
);

  import sb_pkg::*;

  // model queue, slot index doubles as trans id
  logic      m_issued [SbEntries];
  logic      m_valid  [SbEntries];
  logic      m_ex     [SbEntries];
  xlen_t     m_result [SbEntries];
  fu_t       m_fu     [SbEntries];
  reg_addr_t m_rd     [SbEntries];
  trans_id_t m_head;
  trans_id_t m_tail;
  int        m_count;
  // operands due at the next edge
  logic      exp_rs1_valid;
  logic      exp_rs2_valid;
  xlen_t     exp_rs1;
  xlen_t     exp_rs2;
  int        errors;

  assign error_count_o = errors;

  // only issued, unfinished entries that wait on a unit
  always_comb begin
    for (int s = 0; s < int'(SbEntries); s++) begin
      wb_open_o[s] = m_issued[s] && !m_valid[s] && (m_fu[s] != FU_NONE);
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // expected values
  // ----------------------------------------------------------
  // first match in order port 0, port 1, slot 0 .. slot 7
  task automatic predict_operand(input reg_addr_t rs, output logic valid, output xlen_t data);
    valid = 1'b0;
    data  = '0;
    for (int p = 0; p < int'(NrWbPorts); p++) begin
      if (!valid && wb_i[p].valid && !wb_i[p].ex_valid && m_rd[wb_i[p].trans_id] == rs) begin
        valid = 1'b1;
        data  = wb_i[p].data;
      end
    end
    for (int s = 0; s < int'(SbEntries); s++) begin
      if (!valid && m_issued[s] && m_valid[s] && !m_ex[s] && m_rd[s] == rs) begin
        valid = 1'b1;
        data  = m_result[s];
      end
    end
    // x0 is never forwarded
    if (rs == '0) begin
      valid = 1'b0;
    end
  endtask

  // oldest slot by index that targets the register
  function automatic fu_t expected_clobber(input int r);
    fu_t  fu;
    logic found;
    fu    = FU_NONE;
    found = 1'b0;
    for (int s = 0; s < int'(SbEntries); s++) begin
      if (!found && m_issued[s] && m_rd[s] == reg_addr_t'(r)) begin
        fu    = m_fu[s];
        found = 1'b1;
      end
    end
    return (r == 0) ? FU_NONE : fu;
  endfunction

  // ----------------------------------------------------------
  // comparison against the DUT
  // ----------------------------------------------------------
  task automatic check_outputs();
    logic full;
    full = (m_count == int'(SbEntries));
    compare("full", full, sb_full_i);
    compare("issue_valid", decoded_valid_i & ~unresolved_branch_i & ~full, issue_valid_i);
    compare("decoded_ack", issue_ack_i & ~full, decoded_ack_i);
    compare("issue_trans_id", m_tail, issue_i.trans_id);
    compare("issue_fu", decoded_i.fu, issue_i.fu);
    compare("issue_rd", decoded_i.rd, issue_i.rd);
    compare("commit_valid", m_valid[m_head], commit_i.valid);
    // head fields mean something only once it has finished
    if (m_valid[m_head]) begin
      compare("commit_result", m_result[m_head], commit_i.result);
      compare("commit_ex_valid", m_ex[m_head], commit_i.ex_valid);
      compare("commit_rd", m_rd[m_head], commit_i.rd);
      compare("commit_fu", m_fu[m_head], commit_i.fu);
      compare("commit_trans_id", m_head, commit_i.trans_id);
    end
    for (int r = 0; r < int'(NrRegs); r++) begin
      compare($sformatf("clobber[%0d]", r), expected_clobber(r), clobber_i[r]);
    end
    compare("rs1_valid", exp_rs1_valid, rs1_valid_i);
    if (exp_rs1_valid) begin
      compare("rs1_data", exp_rs1, rs1_data_i);
    end
    compare("rs2_valid", exp_rs2_valid, rs2_valid_i);
    if (exp_rs2_valid) begin
      compare("rs2_data", exp_rs2, rs2_data_i);
    end
  endtask

  // ----------------------------------------------------------
  // model update at the clock edge
  // ----------------------------------------------------------
  task automatic update_model();
    logic admit;
    admit = decoded_valid_i && issue_ack_i && (m_count != int'(SbEntries)) && !flush_unissued_i;
    // unit-less entries finish one cycle after admission
    for (int s = 0; s < int'(SbEntries); s++) begin
      if (m_issued[s] && m_fu[s] == FU_NONE) begin
        m_valid[s] = 1'b1;
      end
    end
    for (int p = 0; p < int'(NrWbPorts); p++) begin
      if (wb_i[p].valid && m_issued[wb_i[p].trans_id]) begin
        m_valid[wb_i[p].trans_id]  = 1'b1;
        m_result[wb_i[p].trans_id] = wb_i[p].data;
        m_ex[wb_i[p].trans_id]     = wb_i[p].ex_valid;
      end
    end
    if (commit_ack_i) begin
      m_issued[m_head] = 1'b0;
      m_valid[m_head]  = 1'b0;
      m_head++;
      m_count--;
    end
    if (admit) begin
      m_issued[m_tail] = 1'b1;
      m_valid[m_tail]  = 1'b0;
      m_ex[m_tail]     = 1'b0;
      m_result[m_tail] = '0;
      m_fu[m_tail]     = decoded_i.fu;
      m_rd[m_tail]     = decoded_i.rd;
      m_tail++;
      m_count++;
    end
    // whole queue dropped
    if (flush_i) begin
      for (int s = 0; s < int'(SbEntries); s++) begin
        m_issued[s] = 1'b0;
        m_valid[s]  = 1'b0;
        m_ex[s]     = 1'b0;
      end
      m_head  = '0;
      m_tail  = '0;
      m_count = 0;
    end
  endtask

  task automatic reset_model();
    for (int s = 0; s < int'(SbEntries); s++) begin
      m_issued[s] = 1'b0;
      m_valid[s]  = 1'b0;
      m_ex[s]     = 1'b0;
      m_result[s] = '0;
      m_fu[s]     = FU_NONE;
      m_rd[s]     = '0;
    end
    m_head        = '0;
    m_tail        = '0;
    m_count       = 0;
    exp_rs1_valid = 1'b0;
    exp_rs2_valid = 1'b0;
    exp_rs1       = '0;
    exp_rs2       = '0;
  endtask

  initial begin
    errors = 0;
  end

  // compare first, then predict from the old slots, then step
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      check_outputs();
      predict_operand(rs1_i, exp_rs1_valid, exp_rs1);
      predict_operand(rs2_i, exp_rs2_valid, exp_rs2);
      update_model();
    end
  end

endmodule

`default_nettype wire

// File: hdl/scoreboard.sv
// Instruction scoreboard top
`default_nettype none
`timescale 1ns/100ps

module scoreboard (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // decoder side
  input  sb_pkg::sb_decoded_t                       decoded_i,
  input  logic                                      decoded_valid_i,
  output logic                                      decoded_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                         issue_o,
  output logic                                      issue_valid_o,
  input  logic                                      issue_ack_i,
  // control
  input  logic                                      unresolved_branch_i,
  input  logic                                      flush_unissued_i,
  input  logic                                      flush_i,
  output logic                                      sb_full_o,
  // write-back
  input  sb_pkg::sb_wb_t  [sb_pkg::NrWbPorts-1:0]   wb_i,
  // commit
  output sb_pkg::sb_entry_t                         commit_o,
  input  logic                                      commit_ack_i,
  // clobbered destination registers
  output sb_pkg::fu_t     [sb_pkg::NrRegs-1:0]      clobber_o,
  // operand read
  input  sb_pkg::reg_addr_t                         rs1_i,
  output sb_pkg::xlen_t                             rs1_o,
  output logic                                      rs1_valid_o,
  input  sb_pkg::reg_addr_t                         rs2_i,
  output sb_pkg::xlen_t                             rs2_o,
  output logic                                      rs2_valid_o
);

  import sb_pkg::*;

  // slot array shared by all three blocks
  sb_slot_t [SbEntries-1:0] slots;

  // queue, pointers and handshakes
  sb_entry_store u_entry_store (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .decoded_i           (decoded_i),
    .decoded_valid_i     (decoded_valid_i),
    .decoded_ack_o       (decoded_ack_o),
    .unresolved_branch_i (unresolved_branch_i),
    .flush_unissued_i    (flush_unissued_i),
    .flush_i             (flush_i),
    .sb_full_o           (sb_full_o),
    .issue_o             (issue_o),
    .issue_valid_o       (issue_valid_o),
    .issue_ack_i         (issue_ack_i),
    .wb_i                (wb_i),
    .commit_o            (commit_o),
    .commit_ack_i        (commit_ack_i),
    .slots_o             (slots)
  );

  // pending writers per register
  sb_clobber_table u_clobber_table (
    .slots_i   (slots),
    .clobber_o (clobber_o)
  );

  // bypass towards operand read
  sb_operand_fwd u_operand_fwd (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .wb_i        (wb_i),
    .slots_i     (slots),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

// File: hdl/sb_operand_fwd.sv
// Scoreboard operand forwarding
`default_nettype none
`timescale 1ns/100ps

module sb_operand_fwd (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // source register addresses
  input  sb_pkg::reg_addr_t                        rs1_i,
  input  sb_pkg::reg_addr_t                        rs2_i,
  // results finishing this cycle
  input  sb_pkg::sb_wb_t   [sb_pkg::NrWbPorts-1:0] wb_i,
  // results already stored
  input  sb_pkg::sb_slot_t [sb_pkg::SbEntries-1:0] slots_i,
  // registered operands
  output sb_pkg::xlen_t                            rs1_o,
  output logic                                     rs1_valid_o,
  output sb_pkg::xlen_t                            rs2_o,
  output logic                                     rs2_valid_o
);

  import sb_pkg::*;

  // selected operand before the output register
  typedef struct packed {
    logic  valid;
    xlen_t data;
  } fwd_t;

  fwd_t rs1_sel, rs2_sel;

  // ----------------------------------------------------------
  // fixed priority select
  // ----------------------------------------------------------
  // port 0, port 1, then slot 0 up to slot 7
  // lower priority sources are visited first and get overwritten
  function automatic fwd_t select_operand(
    input reg_addr_t                 rs,
    input sb_wb_t   [NrWbPorts-1:0]  wb,
    input sb_slot_t [SbEntries-1:0]  slots
  );
    fwd_t sel;
    sel = '0;

    // finished entries still waiting for commit
    for (int s = int'(SbEntries) - 1; s >= 0; s--) begin
      if (slots[s].issued && slots[s].entry.valid && !slots[s].entry.ex_valid &&
          slots[s].entry.rd == rs) begin
        sel.valid = 1'b1;
        sel.data  = slots[s].entry.result;
      end
    end

    // results on the write-back ports take rd from the target slot
    for (int p = int'(NrWbPorts) - 1; p >= 0; p--) begin
      if (wb[p].valid && !wb[p].ex_valid && slots[wb[p].trans_id].entry.rd == rs) begin
        sel.valid = 1'b1;
        sel.data  = wb[p].data;
      end
    end

    // x0 always comes from the register file
    if (rs == '0) begin
      sel.valid = 1'b0;
    end
    return sel;
  endfunction

  assign rs1_sel = select_operand(rs1_i, wb_i, slots_i);
  assign rs2_sel = select_operand(rs2_i, wb_i, slots_i);

  // ----------------------------------------------------------
  // output register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_o       <= '0;
      rs1_valid_o <= 1'b0;
      rs2_o       <= '0;
      rs2_valid_o <= 1'b0;
    end else begin
      rs1_o       <= rs1_sel.data;
      rs1_valid_o <= rs1_sel.valid;
      rs2_o       <= rs2_sel.data;
      rs2_valid_o <= rs2_sel.valid;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sb_clobber_table.sv
// Scoreboard register clobber table
`default_nettype none
`timescale 1ns/100ps

module sb_clobber_table (
  // slots as held by the entry store
  input  sb_pkg::sb_slot_t [sb_pkg::SbEntries-1:0] slots_i,
  // unit that will write each integer register
  output sb_pkg::fu_t      [sb_pkg::NrRegs-1:0]    clobber_o
);

  import sb_pkg::*;

  // ----------------------------------------------------------
  // per register selection
  // ----------------------------------------------------------
  always_comb begin : clobber_sel
    // nobody writes the register by default
    for (int unsigned r = 0; r < NrRegs; r++) begin
      clobber_o[r] = FU_NONE;
    end

    // x0 is hardwired so the walk starts at register one
    for (int unsigned r = 1; r < NrRegs; r++) begin
      // walk from the top so the lowest slot index wins
      for (int s = int'(SbEntries) - 1; s >= 0; s--) begin
        if (slots_i[s].issued && slots_i[s].entry.rd == reg_addr_t'(r)) begin
          clobber_o[r] = slots_i[s].entry.fu;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/sb_entry_store.sv
// Scoreboard entry store
`default_nettype none
`timescale 1ns/100ps

module sb_entry_store (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // decoder side
  input  sb_pkg::sb_decoded_t                         decoded_i,
  input  logic                                        decoded_valid_i,
  output logic                                        decoded_ack_o,
  // control
  input  logic                                        unresolved_branch_i,
  input  logic                                        flush_unissued_i,
  input  logic                                        flush_i,
  output logic                                        sb_full_o,
  // issue side
  output sb_pkg::sb_entry_t                           issue_o,
  output logic                                        issue_valid_o,
  input  logic                                        issue_ack_i,
  // write-back ports
  input  sb_pkg::sb_wb_t   [sb_pkg::NrWbPorts-1:0]    wb_i,
  // commit port
  output sb_pkg::sb_entry_t                           commit_o,
  input  logic                                        commit_ack_i,
  // slot array towards clobber and forwarding logic
  output sb_pkg::sb_slot_t [sb_pkg::SbEntries-1:0]    slots_o
);

  import sb_pkg::*;

  sb_slot_t [SbEntries-1:0] slots_q, slots_n;
  trans_id_t issue_ptr_q, issue_ptr_n;
  trans_id_t commit_ptr_q, commit_ptr_n;
  sb_cnt_t   cnt_q, cnt_n;
  logic      full;
  logic      issue_en;

  // ----------------------------------------------------------
  // issue handshake
  // ----------------------------------------------------------
  // depth is a power of two, so the count msb is the full flag
  assign full      = cnt_q[SbIdxBits];
  assign sb_full_o = full;

  // incoming instruction takes the slot under the issue pointer
  always_comb begin
    issue_o          = '0;
    issue_o.fu       = decoded_i.fu;
    issue_o.rd       = decoded_i.rd;
    issue_o.trans_id = issue_ptr_q;
  end

  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o = issue_ack_i & ~full;
  // an unissued flush drops the instruction in flight
  assign issue_en      = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // head of the queue straight to commit
  assign commit_o = slots_q[commit_ptr_q].entry;
  assign slots_o  = slots_q;

  // ----------------------------------------------------------
  // slot update
  // ----------------------------------------------------------
  always_comb begin : slot_update
    slots_n = slots_q;

    // admission
    if (issue_en) begin
      slots_n[issue_ptr_q].issued = 1'b1;
      slots_n[issue_ptr_q].entry  = issue_o;
    end

    // no unit attached, entry finishes on its own
    for (int unsigned s = 0; s < SbEntries; s++) begin
      if (slots_q[s].issued && slots_q[s].entry.fu == FU_NONE) begin
        slots_n[s].entry.valid = 1'b1;
      end
    end

    // write-back
    // stale results after a flush hit unissued slots and are dropped
    for (int unsigned p = 0; p < NrWbPorts; p++) begin
      if (wb_i[p].valid && slots_q[wb_i[p].trans_id].issued) begin
        slots_n[wb_i[p].trans_id].entry.valid    = 1'b1;
        slots_n[wb_i[p].trans_id].entry.result   = wb_i[p].data;
        slots_n[wb_i[p].trans_id].entry.ex_valid = wb_i[p].ex_valid;
      end
    end

    // commit frees the head slot
    if (commit_ack_i) begin
      slots_n[commit_ptr_q].issued      = 1'b0;
      slots_n[commit_ptr_q].entry.valid = 1'b0;
    end

    // flush wins over everything above
    if (flush_i) begin
      for (int unsigned s = 0; s < SbEntries; s++) begin
        slots_n[s].issued         = 1'b0;
        slots_n[s].entry.valid    = 1'b0;
        slots_n[s].entry.ex_valid = 1'b0;
      end
    end
  end

  // pointers wrap naturally at the queue depth
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + trans_id_t'(commit_ack_i);
  assign cnt_n        = flush_i ? '0 : cnt_q + sb_cnt_t'(issue_en) - sb_cnt_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slots_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      slots_q      <= slots_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  // ----------------------------------------------------------
  // checks on the surrounding pipeline
  // ----------------------------------------------------------
  // issue stage only acks what was offered
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue ack without a valid instruction");

  // commit stage only retires a finished head
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_o.valid)
    else $error("commit ack on an unfinished head entry");

  // two units never finish the same instruction together
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_i[0].valid && wb_i[1].valid) |-> (wb_i[0].trans_id != wb_i[1].trans_id))
    else $error("write-back ports share a trans id");

endmodule

`default_nettype wire

// File: hdl/sb_pkg.sv
// Scoreboard shared definitions
`default_nettype none

package sb_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  // queue depth, must stay a power of two for the full flag
  localparam int unsigned SbEntries   = 8;
  // trans id and pointer width
  localparam int unsigned SbIdxBits   = 3;
  // functional units writing results back
  localparam int unsigned NrWbPorts   = 2;
  // integer register file
  localparam int unsigned RegAddrBits = 5;
  localparam int unsigned NrRegs      = 32;
  // data path width
  localparam int unsigned XLen        = 32;

  // ----------------------------------------------------------
  // plain vector types
  // ----------------------------------------------------------
  typedef logic [SbIdxBits-1:0]   trans_id_t;
  typedef logic [RegAddrBits-1:0] reg_addr_t;
  typedef logic [XLen-1:0]        xlen_t;
  // occupancy count, msb set means all slots taken
  typedef logic [SbIdxBits:0]     sb_cnt_t;

  // functional unit an instruction is dispatched to
  // none means the entry completes without a write-back
  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_LOAD,
    FU_MULT
  } fu_t;

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------
  // what the decoder hands over
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
  } sb_decoded_t;

  // one queue entry as seen by issue and commit
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      valid;     // result present
    logic      ex_valid;  // unit raised an exception
    trans_id_t trans_id;
  } sb_entry_t;

  // one write-back port
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
  } sb_wb_t;

  // stored slot, issued marks it as occupied
  typedef struct packed {
    logic      issued;
    sb_entry_t entry;
  } sb_slot_t;

endpackage

`default_nettype wire
